/* Makefile */
TOP = tb_rvvi_trace

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

/* hdl/hart_events.sv */
// NMI cause capture, sticky interrupt record and halt request stretching
module hart_events (
   input  logic        rvvi,
   input  logic        arst_n_i,
   input  logic        data_err_i,
   input  logic        data_rvalid_i,
   input  logic [31:0] irq_i,
   input  logic        debug_req_i,
   input  logic        irq_clr_i,
   output logic [31:0] nmi_cause_o,
   output logic [31:0] irq_seen_o,
   output logic        halt_req_o
);

   `include "rvvi_macros.svh"

   localparam int HOLD_W = $clog2(`RVVI_HALT_HOLD + 1);

   logic              data_err_q;
   logic [HOLD_W-1:0] hold_cnt_q;

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         data_err_q  <= 1'b0;
         nmi_cause_o <= '0;
         irq_seen_o  <= '0;
         hold_cnt_q  <= '0;
         halt_req_o  <= 1'b0;
      end else begin
         data_err_q <= data_err_i;
         // Rising bus error, rvalid tells a load from a store
         if (data_err_i && !data_err_q) begin
            nmi_cause_o <= data_rvalid_i ? `RVVI_NMI_LOAD : `RVVI_NMI_STORE;
         end
         // Sticky record, cleared by the host
         irq_seen_o <= (irq_clr_i ? 32'd0 : irq_seen_o) | (irq_i & `RVVI_IRQ_MASK);
         // Reload while debug request is high, then count down
         if (debug_req_i) begin
            hold_cnt_q <= HOLD_W'(`RVVI_HALT_HOLD);
         end else if (hold_cnt_q != '0) begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
         end
         halt_req_o <= debug_req_i || (hold_cnt_q != '0);
      end
   end

endmodule

/* hdl/retire_decode.sv */
// Stage 2: one-hot writeback mask, CSR slot mapping and masking, Zicsr detection
module retire_decode (
   input  logic                rvvi,
   input  logic                arst_n_i,
   input  rvvi_pkg::rvfi_rec_t rec_i,
   output rvvi_pkg::ret_dec_t  dec_o
);

   import rvvi_pkg::*;

   `include "rvvi_macros.svh"

   // SYSTEM major opcode
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   insn_u      insn;
   logic       wb_en;
   logic       slot_match;
   logic [2:0] slot;
   logic       zicsr;

   assign insn = rec_i.insn;

   // No GPR write for x0 or for a trapped instruction
   assign wb_en = rec_i.valid && !rec_i.trap && (rec_i.rd_addr != 5'd0);

   // Map CSR address onto a shadow slot
   always_comb begin
      slot_match = 1'b1;
      slot       = 3'd0;
      case (rec_i.csr_addr)
         `RVVI_CSR_MSTATUS:  slot = 3'd0;
         `RVVI_CSR_MIE:      slot = 3'd1;
         `RVVI_CSR_MTVEC:    slot = 3'd2;
         `RVVI_CSR_MSCRATCH: slot = 3'd3;
         `RVVI_CSR_MEPC:     slot = 3'd4;
         `RVVI_CSR_MCAUSE:   slot = 3'd5;
         `RVVI_CSR_MTVAL:    slot = 3'd6;
         `RVVI_CSR_MIP:      slot = 3'd7;
         default:            slot_match = 1'b0;
      endcase
   end

   // Opcode class and funct3 from reg view, CSR number from csr view
   // funct3 of 000 and 100 are not Zicsr
   assign zicsr = (insn.r.opcode == OPC_SYSTEM) &&
                  (insn.r.funct3[1:0] != 2'b00) &&
                  (insn.c.csr == rec_i.csr_addr);

   ////////////////////
   // Decoded record register
   ////////////////////

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dec_o <= '0;
      end else begin
         dec_o.valid       <= rec_i.valid;
         dec_o.x_wb        <= wb_en ? (32'd1 << rec_i.rd_addr) : 32'd0;
         dec_o.rd_addr     <= rec_i.rd_addr;
         dec_o.rd_wdata    <= rec_i.rd_wdata;
         // Zero mask means the CSR was only read
         dec_o.csr_hit     <= rec_i.valid && slot_match && (rec_i.csr_wmask != 32'd0);
         dec_o.csr_slot    <= slot;
         dec_o.csr_value   <= rec_i.csr_wdata & rec_i.csr_wmask;
         dec_o.is_csr_insn <= rec_i.valid && zicsr;
         dec_o.trap        <= rec_i.valid && rec_i.trap;
      end
   end

endmodule

/* hdl/rvfi_capture.sv */
// Stage 1: retirement record register and order-number continuity check
module rvfi_capture (
   input  logic                rvvi,
   input  logic                arst_n_i,
   input  rvvi_pkg::rvfi_rec_t rec_i,
   output rvvi_pkg::rvfi_rec_t rec_o,
   output logic                gap_o
);

   // Order of the last valid retirement
   logic [63:0] last_order_q;
   // Set once the first record after reset was seen
   logic        seen_first_q;
   logic        order_break;

   // Expected order is previous plus one
   assign order_break = seen_first_q && (rec_i.order != (last_order_q + 64'd1));

   ////////////////////
   // Record register
   ////////////////////

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rec_o <= '0;
      end else if (rec_i.valid) begin
         rec_o <= rec_i;
      end else begin
         // Idle cycle, nothing retires
         rec_o <= '0;
      end
   end

   ////////////////////
   // Continuity tracking
   ////////////////////

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         last_order_q <= '0;
         seen_first_q <= 1'b0;
         gap_o        <= 1'b0;
      end else begin
         // Flag travels with the record in rec_o
         gap_o <= rec_i.valid && order_break;
         if (rec_i.valid) begin
            last_order_q <= rec_i.order;
            seen_first_q <= 1'b1;
         end
      end
   end

endmodule

/* hdl/rvvi_macros.svh */
// CSR addresses, register-map offsets, halt stretch length and NMI cause codes
`ifndef RVVI_MACROS_SVH
`define RVVI_MACROS_SVH

////////////////////
// Shadowed machine CSRs
////////////////////

// Slot order follows the address order below
`define RVVI_CSR_MSTATUS  12'h300
`define RVVI_CSR_MIE      12'h304
`define RVVI_CSR_MTVEC    12'h305
`define RVVI_CSR_MSCRATCH 12'h340
`define RVVI_CSR_MEPC     12'h341
`define RVVI_CSR_MCAUSE   12'h342
`define RVVI_CSR_MTVAL    12'h343
`define RVVI_CSR_MIP      12'h344

// Number of shadow CSR slots
`define RVVI_CSR_SLOTS 8

////////////////////
// Hart side-band events
////////////////////

// Cycles of halt request after debug request drops
`define RVVI_HALT_HOLD 5

// NMI causes for bus errors
`define RVVI_NMI_LOAD  32'd1024
`define RVVI_NMI_STORE 32'd1025

// Interrupt lines that are recorded
// MSI, MTI, MEI and the sixteen local lines
`define RVVI_IRQ_MASK 32'hFFFF_0888

////////////////////
// Wishbone register map, byte offsets
////////////////////

`define RVVI_MAP_GPR     8'h00
`define RVVI_MAP_CSR     8'h80
`define RVVI_MAP_RETIRED 8'hC0
`define RVVI_MAP_GAPS    8'hC4
`define RVVI_MAP_NMI     8'hC8
`define RVVI_MAP_IRQ     8'hCC
`define RVVI_MAP_TRAPS   8'hD0

`endif

/* hdl/rvvi_pkg.sv */
// RVFI retirement record, decoded record, instruction word union, Wishbone request
package rvvi_pkg;

   ////////////////////
   // Retirement record from the core
   ////////////////////

   typedef struct packed {
      logic        valid;
      logic [63:0] order;
      logic [31:0] insn;
      logic        trap;
      logic        intr;
      logic [4:0]  rd_addr;
      logic [31:0] rd_wdata;
      logic [31:0] pc_rdata;
      logic [11:0] csr_addr;
      logic [31:0] csr_wdata;
      logic [31:0] csr_wmask;
   } rvfi_rec_t;

   ////////////////////
   // Instruction word views
   ////////////////////

   // Zicsr layout, I-type with the CSR number on top
   typedef struct packed {
      logic [11:0] csr;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } insn_csr_t;

   // R-type layout
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } insn_reg_t;

   typedef union packed {
      insn_csr_t c;
      insn_reg_t r;
   } insn_u;

   ////////////////////
   // Decoded retirement
   ////////////////////

   typedef struct packed {
      logic        valid;
      logic [31:0] x_wb;
      logic [4:0]  rd_addr;
      logic [31:0] rd_wdata;
      logic        csr_hit;
      logic [2:0]  csr_slot;
      logic [31:0] csr_value;
      logic        is_csr_insn;
      logic        trap;
   } ret_dec_t;

   // Wishbone classic request from the host
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [7:0]  adr;
      logic [31:0] dat;
   } wb_req_t;

endpackage

/* hdl/rvvi_trace_top.sv */
// RVVI trace unit top: capture, decode and state stages, hart events, Wishbone readout
module rvvi_trace_top (
   input  logic                rvvi,
   input  logic                arst_n_i,
   input  rvvi_pkg::rvfi_rec_t rvfi_i,
   input  logic                data_err_i,
   input  logic                data_rvalid_i,
   input  logic [31:0]         irq_i,
   input  logic                debug_req_i,
   input  rvvi_pkg::wb_req_t   wb_i,
   output logic                wb_ack_o,
   output logic [31:0]         wb_dat_o,
   output logic                halt_req_o
);

   import rvvi_pkg::*;

   `include "rvvi_macros.svh"

   // Pipeline
   rvfi_rec_t cap_rec;
   ret_dec_t  dec_rec;
   logic      gap_inc;

   // Readout bundles
   logic [4:0]                       gpr_idx;
   logic [31:0]                      gpr_rd_data;
   logic [`RVVI_CSR_SLOTS-1:0][31:0] csr_bank;
   logic [31:0]                      retired_cnt;
   logic [31:0]                      gap_cnt;
   logic [31:0]                      trap_cnt;
   logic [31:0]                      nmi_cause;
   logic [31:0]                      irq_seen;
   logic                             irq_clr;
   logic                             cnt_clr;

   ////////////////////
   // Trace pipeline
   ////////////////////

   rvfi_capture i_rvfi_capture (
      .rvvi     (rvvi),
      .arst_n_i (arst_n_i),
      .rec_i    (rvfi_i),
      .rec_o    (cap_rec),
      .gap_o    (gap_inc)
   );

   retire_decode i_retire_decode (
      .rvvi     (rvvi),
      .arst_n_i (arst_n_i),
      .rec_i    (cap_rec),
      .dec_o    (dec_rec)
   );

   shadow_state i_shadow_state (
      .rvvi       (rvvi),
      .arst_n_i   (arst_n_i),
      .dec_i      (dec_rec),
      .gap_i      (gap_inc),
      .clr_i      (cnt_clr),
      .gpr_idx_i  (gpr_idx),
      .gpr_o      (gpr_rd_data),
      .csr_bank_o (csr_bank),
      .retired_o  (retired_cnt),
      .gaps_o     (gap_cnt),
      .traps_o    (trap_cnt)
   );

   // Side-band pins
   hart_events i_hart_events (
      .rvvi          (rvvi),
      .arst_n_i      (arst_n_i),
      .data_err_i    (data_err_i),
      .data_rvalid_i (data_rvalid_i),
      .irq_i         (irq_i),
      .debug_req_i   (debug_req_i),
      .irq_clr_i     (irq_clr),
      .nmi_cause_o   (nmi_cause),
      .irq_seen_o    (irq_seen),
      .halt_req_o    (halt_req_o)
   );

   // Host access
   wb_readout i_wb_readout (
      .rvvi        (rvvi),
      .arst_n_i    (arst_n_i),
      .wb_i        (wb_i),
      .wb_ack_o    (wb_ack_o),
      .wb_dat_o    (wb_dat_o),
      .gpr_idx_o   (gpr_idx),
      .gpr_i       (gpr_rd_data),
      .csr_bank_i  (csr_bank),
      .retired_i   (retired_cnt),
      .gaps_i      (gap_cnt),
      .traps_i     (trap_cnt),
      .nmi_cause_i (nmi_cause),
      .irq_seen_i  (irq_seen),
      .irq_clr_o   (irq_clr),
      .cnt_clr_o   (cnt_clr)
   );

endmodule

/* hdl/shadow_state.sv */
// Stage 3 shadow GPR file, shadow CSR slots and retirement counters
`include "rvvi_macros.svh"

module shadow_state (
   input  logic                                   rvvi,
   input  logic                                   arst_n_i,
   input  rvvi_pkg::ret_dec_t                     dec_i,
   input  logic                                   gap_i,
   input  logic                                   clr_i,
   input  logic [4:0]                             gpr_idx_i,
   output logic [31:0]                            gpr_o,
   output logic [`RVVI_CSR_SLOTS-1:0][31:0]       csr_bank_o,
   output logic [31:0]                            retired_o,
   output logic [31:0]                            gaps_o,
   output logic [31:0]                            traps_o
);

   // Shadow of x0..x31
   // x0 never gets a write bit
   logic [31:0] gpr_q [32];

   ////////////////////
   // Shadow GPR file
   ////////////////////

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < 32; i++) begin
            gpr_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 32; i++) begin
            if (dec_i.x_wb[i]) begin
               gpr_q[i] <= dec_i.rd_wdata;
            end
         end
      end
   end

   // Host read port
   assign gpr_o = gpr_q[gpr_idx_i];

   ////////////////////
   // Shadow CSR slots
   ////////////////////

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         csr_bank_o <= '0;
      end else if (dec_i.csr_hit) begin
         // Value arrives already masked
         csr_bank_o[dec_i.csr_slot] <= dec_i.csr_value;
      end
   end

   ////////////////////
   // Counters
   ////////////////////

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         retired_o <= '0;
         gaps_o    <= '0;
         traps_o   <= '0;
      end else begin
         // Every valid retirement counts, trapped ones too
         if (dec_i.valid) begin
            retired_o <= retired_o + 32'd1;
         end
         // Host clear wins over a same-cycle event
         if (clr_i) begin
            gaps_o  <= '0;
            traps_o <= '0;
         end else begin
            if (gap_i) begin
               gaps_o <= gaps_o + 32'd1;
            end
            if (dec_i.valid && dec_i.trap) begin
               traps_o <= traps_o + 32'd1;
            end
         end
      end
   end

endmodule

/* hdl/wb_readout.sv */
// Wishbone classic slave with register map decode and clear strobes
`include "rvvi_macros.svh"

module wb_readout (
   input  logic                             rvvi,
   input  logic                             arst_n_i,
   input  rvvi_pkg::wb_req_t                wb_i,
   output logic                             wb_ack_o,
   output logic [31:0]                      wb_dat_o,
   output logic [4:0]                       gpr_idx_o,
   input  logic [31:0]                      gpr_i,
   input  logic [`RVVI_CSR_SLOTS-1:0][31:0] csr_bank_i,
   input  logic [31:0]                      retired_i,
   input  logic [31:0]                      gaps_i,
   input  logic [31:0]                      traps_i,
   input  logic [31:0]                      nmi_cause_i,
   input  logic [31:0]                      irq_seen_i,
   output logic                             irq_clr_o,
   output logic                             cnt_clr_o
);

   logic        req;
   logic [7:0]  word_adr;
   logic [31:0] rd_data;

   // New request and not the tail of one already acked
   assign req      = wb_i.cyc && wb_i.stb && !wb_ack_o;
   assign word_adr = {wb_i.adr[7:2], 2'b00};

   // GPR index straight from the word address
   assign gpr_idx_o = wb_i.adr[6:2];

   // Clear strobes take effect at the ack edge
   assign irq_clr_o = req && wb_i.we && (word_adr == `RVVI_MAP_IRQ);
   assign cnt_clr_o = req && wb_i.we && (word_adr == `RVVI_MAP_GAPS);

   ////////////////////
   // Read mux
   ////////////////////

   always_comb begin
      rd_data = 32'd0;
      if (word_adr < `RVVI_MAP_CSR) begin
         rd_data = gpr_i;
      end else if (word_adr < `RVVI_MAP_CSR + 8'(4 * `RVVI_CSR_SLOTS)) begin
         rd_data = csr_bank_i[word_adr[4:2]];
      end else begin
         case (word_adr)
            `RVVI_MAP_RETIRED: rd_data = retired_i;
            `RVVI_MAP_GAPS:    rd_data = gaps_i;
            `RVVI_MAP_NMI:     rd_data = nmi_cause_i;
            `RVVI_MAP_IRQ:     rd_data = irq_seen_i;
            `RVVI_MAP_TRAPS:   rd_data = traps_i;
            default:           rd_data = 32'd0;
         endcase
      end
   end

   // Single-cycle ack
   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= req;
      end
   end

   // Read data lands with the ack
   always_ff @(posedge rvvi) begin
      if (req) begin
         wb_dat_o <= wb_i.we ? 32'd0 : rd_data;
      end
   end

endmodule

/* src.f */
+incdir+hdl
hdl/rvvi_pkg.sv
hdl/rvfi_capture.sv
hdl/retire_decode.sv
hdl/shadow_state.sv
hdl/hart_events.sv
hdl/wb_readout.sv
hdl/rvvi_trace_top.sv
test/tb_clock.sv
test/tb_rvvi_trace.sv

/* test/tb_clock.sv */
// Testbench clock and reset generator
module tb_clock (
   output logic clk_o,
   output logic arst_n_o
);

   timeunit 1ns;
   timeprecision 1ps;

   // 20 ns period
   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   // Reset for four cycles, released on a falling edge
   initial begin
      arst_n_o = 1'b0;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;
   end

endmodule

/* test/tb_rvvi_trace.sv */
// RVVI trace testbench with stimulus, scoreboard, Wishbone reads and checking assertions
module tb_rvvi_trace;

   timeunit 1ns;
   timeprecision 1ps;

   import rvvi_pkg::*;

   `include "rvvi_macros.svh"

   localparam int CYCLE_LIMIT = 4000;
   // Shadowed CSRs in slot order
   localparam logic [11:0] CSR_ADDRS [`RVVI_CSR_SLOTS] = '{
      `RVVI_CSR_MSTATUS, `RVVI_CSR_MIE, `RVVI_CSR_MTVEC, `RVVI_CSR_MSCRATCH,
      `RVVI_CSR_MEPC, `RVVI_CSR_MCAUSE, `RVVI_CSR_MTVAL, `RVVI_CSR_MIP};

   logic        rvvi;
   logic        arst_n;
   rvfi_rec_t   rvfi_in;
   logic        data_err;
   logic        data_rvalid;
   logic [31:0] irq;
   logic        debug_req;
   wb_req_t     wb_req;
   logic        wb_ack;
   logic [31:0] wb_dat;
   logic        halt_req;

   ////////////////////
   // Scoreboard state
   ////////////////////

   logic [31:0] gpr_exp [32];
   logic [31:0] csr_exp [`RVVI_CSR_SLOTS];
   logic [31:0] retired_exp;
   logic [31:0] gaps_exp;
   logic [31:0] traps_exp;
   logic [31:0] irq_exp;
   logic [63:0] next_order;
   logic        order_started;

   integer seed = 32'hed09_fa4d;
   int     value_errors;
   int     protocol_errors;
   int     cycles;

   tb_clock i_tb_clock (
      .clk_o    (rvvi),
      .arst_n_o (arst_n)
   );

   rvvi_trace_top i_rvvi_trace_top (
      .rvvi          (rvvi),
      .arst_n_i      (arst_n),
      .rvfi_i        (rvfi_in),
      .data_err_i    (data_err),
      .data_rvalid_i (data_rvalid),
      .irq_i         (irq),
      .debug_req_i   (debug_req),
      .wb_i          (wb_req),
      .wb_ack_o      (wb_ack),
      .wb_dat_o      (wb_dat),
      .halt_req_o    (halt_req)
   );

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp) else begin
         value_errors++;
         $display("mismatch %s expected %h actual %h", name, exp, got);
      end
   endtask

   // Drive one record for one cycle and apply the retirement rules
   task automatic send_record(input rvfi_rec_t rec);
      @(negedge rvvi);
      rvfi_in = rec;
      if (rec.valid) begin
         retired_exp++;
         if (rec.trap) begin
            traps_exp++;
         end else if (rec.rd_addr != 5'd0) begin
            gpr_exp[rec.rd_addr] = rec.rd_wdata;
         end
         // Only written bits of a shadowed CSR land
         for (int s = 0; s < `RVVI_CSR_SLOTS; s++) begin
            if (rec.csr_wmask != 32'd0 && rec.csr_addr == CSR_ADDRS[s]) begin
               csr_exp[s] = rec.csr_wdata & rec.csr_wmask;
            end
         end
      end
   endtask

   // Next record in order
   // A skip jumps one order number
   task automatic next_record(input bit skip, output rvfi_rec_t rec);
      logic [31:0] rnd;
      rnd = $random(seed);
      if (skip && order_started) begin
         next_order = next_order + 64'd2;
         gaps_exp++;
      end else begin
         next_order = next_order + 64'd1;
      end
      order_started = 1'b1;
      rec = '0;
      rec.valid = 1'b1;
      rec.order = next_order;
      rec.pc_rdata = {rnd[31:2], 2'b00};
   endtask

   // Idle input and let the three stages drain
   task automatic settle_pipeline();
      send_record('0);
      repeat (3) @(negedge rvvi);
   endtask

   task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int waited;
      @(negedge rvvi);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      waited = 0;
      do begin
         @(negedge rvvi);
         waited++;
      end while (!wb_ack && waited < 8);
      if (!wb_ack) begin
         protocol_errors++;
         $display("no Wishbone ack within 8 cycles at address %h", adr);
      end
      rdat = wb_dat;
      // Master drops the strobe after the ack
      wb_req = '0;
   endtask

   task automatic expect_reg(input string name, input logic [7:0] adr, input logic [31:0] exp);
      logic [31:0] got;
      wb_access(1'b0, adr, 32'd0, got);
      check_word(name, exp, got);
   endtask

   task automatic pulse_data_err(input logic rvalid);
      @(negedge rvvi);
      data_rvalid = rvalid;
      data_err = 1'b1;
      @(negedge rvvi);
      data_err = 1'b0;
      data_rvalid = 1'b0;
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      rvfi_rec_t   rec;
      logic [31:0] rnd;
      logic [31:0] data;
      rvfi_in = '0;
      data_err = 1'b0;
      data_rvalid = 1'b0;
      irq = '0;
      debug_req = 1'b0;
      wb_req = '0;
      for (int i = 0; i < 32; i++) begin
         gpr_exp[i] = '0;
      end
      for (int s = 0; s < `RVVI_CSR_SLOTS; s++) begin
         csr_exp[s] = '0;
      end
      retired_exp = '0;
      gaps_exp = '0;
      traps_exp = '0;
      irq_exp = '0;
      next_order = 64'd100;
      order_started = 1'b0;
      value_errors = 0;
      protocol_errors = 0;

      @(posedge arst_n);
      @(negedge rvvi);
      check_word("wb_ack_o", 32'd0, 32'(wb_ack));
      check_word("halt_req_o", 32'd0, 32'(halt_req));
      expect_reg("retired", `RVVI_MAP_RETIRED, 32'd0);

      // Random GPR writes with idle cycles, traps and order skips
      for (int i = 0; i < 60; i++) begin
         rnd = $random(seed);
         if (rnd[2:0] == 3'd0) begin
            send_record('0);
         end else begin
            next_record(rnd[6:4] == 3'd0, rec);
            rnd = $random(seed);
            rec.rd_addr = rnd[4:0];
            rec.trap = (rnd[9:8] == 2'd0);
            rec.rd_wdata = $random(seed);
            rec.insn = $random(seed);
            send_record(rec);
         end
      end
      // Directed x0 write that the shadow file must drop
      next_record(1'b0, rec);
      rec.rd_wdata = 32'hA5A5_5A5A;
      send_record(rec);
      settle_pipeline();
      for (int i = 0; i < 32; i++) begin
         expect_reg($sformatf("x%0d", i), `RVVI_MAP_GPR + 8'(4 * i), gpr_exp[i]);
      end

      // CSRRW to every slot, then zero masks, then an unshadowed CSR
      for (int pass = 0; pass < 2; pass++) begin
         for (int s = 0; s < `RVVI_CSR_SLOTS; s++) begin
            next_record(1'b0, rec);
            rec.csr_addr = CSR_ADDRS[s];
            rec.insn = {CSR_ADDRS[s], 5'd1, 3'b001, 5'd0, 7'b1110011};
            rec.csr_wdata = $random(seed);
            rnd = $random(seed);
            rec.csr_wmask = (pass == 1) ? 32'd0 : ((rnd == 32'd0) ? 32'hFFFF_FFFF : rnd);
            send_record(rec);
         end
      end
      next_record(1'b0, rec);
      rec.csr_addr = 12'hB00;
      rec.csr_wdata = $random(seed);
      rec.csr_wmask = 32'hFFFF_FFFF;
      send_record(rec);
      settle_pipeline();
      for (int s = 0; s < `RVVI_CSR_SLOTS; s++) begin
         expect_reg($sformatf("csr slot %0d", s), `RVVI_MAP_CSR + 8'(4 * s), csr_exp[s]);
      end

      // Counter readback and the clear write
      expect_reg("retired", `RVVI_MAP_RETIRED, retired_exp);
      expect_reg("gaps", `RVVI_MAP_GAPS, gaps_exp);
      expect_reg("traps", `RVVI_MAP_TRAPS, traps_exp);
      wb_access(1'b1, `RVVI_MAP_GAPS, 32'd0, data);
      gaps_exp = '0;
      traps_exp = '0;
      expect_reg("gaps", `RVVI_MAP_GAPS, gaps_exp);
      expect_reg("traps", `RVVI_MAP_TRAPS, traps_exp);
      expect_reg("retired", `RVVI_MAP_RETIRED, retired_exp);

      // Bus error on a load and then on a store
      pulse_data_err(1'b1);
      expect_reg("nmi_cause", `RVVI_MAP_NMI, `RVVI_NMI_LOAD);
      pulse_data_err(1'b0);
      expect_reg("nmi_cause", `RVVI_MAP_NMI, `RVVI_NMI_STORE);

      // Interrupt pulses stay recorded until cleared
      for (int k = 0; k < 3; k++) begin
         @(negedge rvvi);
         irq = $random(seed);
         irq_exp = irq_exp | (irq & `RVVI_IRQ_MASK);
      end
      @(negedge rvvi);
      irq = '0;
      expect_reg("irq_seen", `RVVI_MAP_IRQ, irq_exp);
      wb_access(1'b1, `RVVI_MAP_IRQ, 32'd0, data);
      irq_exp = '0;
      expect_reg("irq_seen", `RVVI_MAP_IRQ, irq_exp);

      // Long debug request and a single-cycle one
      @(negedge rvvi);
      debug_req = 1'b1;
      repeat (3) @(negedge rvvi);
      debug_req = 1'b0;
      repeat (10) @(negedge rvvi);
      debug_req = 1'b1;
      @(negedge rvvi);
      debug_req = 1'b0;
      repeat (10) @(negedge rvvi);

      $display("checks done: %0d value errors, %0d protocol errors",
               value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   // Run limit
   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge rvvi);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
   end

   ////////////////////
   // Protocol checks
   ////////////////////

   assert property (@(posedge rvvi) disable iff (!arst_n)
         (wb_req.cyc && wb_req.stb && !wb_ack) |=> wb_ack)
      else begin
         protocol_errors++;
         $display("Wishbone ack did not follow the request by one cycle");
      end

   assert property (@(posedge rvvi) disable iff (!arst_n) wb_ack |=> !wb_ack)
      else begin
         protocol_errors++;
         $display("Wishbone ack held longer than one cycle");
      end

   assert property (@(posedge rvvi) disable iff (!arst_n)
         $rose(wb_ack) |-> $past(wb_req.cyc && wb_req.stb))
      else begin
         protocol_errors++;
         $display("Wishbone ack without a request");
      end

   assert property (@(posedge rvvi) disable iff (!arst_n) debug_req |=> halt_req)
      else begin
         protocol_errors++;
         $display("halt request not raised one cycle after debug request");
      end

   // Five cycles of hold before the halt request drops
   assert property (@(posedge rvvi) disable iff (!arst_n)
         $fell(debug_req) |=> halt_req ##1 halt_req ##1 halt_req ##1 halt_req ##1 halt_req
                              ##1 !halt_req)
      else begin
         protocol_errors++;
         $display("halt request hold after debug request is not five cycles");
      end

endmodule
